// File: hdl/input_skew.sv
`timescale 1ns/1ps

module input_skew (
  input  logic             clk,
  input  logic             reset,
  input  logic             i_clear,
  input  matmul_pkg::vec_t i_word,
  output matmul_pkg::vec_t o_word
);
  import matmul_pkg::*;

  elem_t [N-1:0] lanes_in;
  elem_t [N-1:0] lanes_out;

  assign lanes_in     = i_word;
  assign lanes_out[0] = lanes_in[0];

  // lane k is held back k cycles so the grid sees a diagonal wavefront
  for (genvar k = 1; k < N; k++) begin : g_lane
    elem_t chain [k];

    always_ff @(posedge clk) begin
      if (reset || i_clear) begin
        for (int s = 0; s < k; s++) begin
          chain[s] <= '0;
        end
      end else begin
        chain[0] <= lanes_in[k];
        for (int s = 1; s < k; s++) begin
          chain[s] <= chain[s-1];
        end
      end
    end

    assign lanes_out[k] = chain[k-1];
  end

  assign o_word = lanes_out;

endmodule

// File: hdl/matmul_ctrl.sv
`timescale 1ns/1ps

module matmul_ctrl (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          i_start,
  output logic                          o_done,
  output logic [matmul_pkg::AWIDTH-1:0] o_a_addr,
  output logic [matmul_pkg::AWIDTH-1:0] o_b_addr,
  output logic                          o_skew_clear,
  output matmul_pkg::row_strobe_t       o_row_latch
);
  import matmul_pkg::*;

  logic [CNT_WIDTH-1:0] cnt;
  logic                 fetch;

  // cycle counter, frozen at DONE_COUNT once done is raised
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      cnt    <= '0;
      o_done <= 1'b0;
    end else if (cnt == CNT_WIDTH'(DONE_COUNT)) begin
      o_done <= 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // words 0 to N-1 are requested while the count is below N
  assign fetch = (cnt < CNT_WIDTH'(N));

  // one generator per memory, both step from the idle address through 0..N-1
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      o_a_addr <= AWIDTH'(ADDR_IDLE);
      o_b_addr <= AWIDTH'(ADDR_IDLE);
    end else if (fetch) begin
      // idle address wraps to word 0 on the first step
      o_a_addr <= o_a_addr + 1'b1;
      o_b_addr <= o_b_addr + 1'b1;
    end else begin
      o_a_addr <= AWIDTH'(ADDR_IDLE);
      o_b_addr <= AWIDTH'(ADDR_IDLE);
    end
  end

  // skew registers are flushed before the first word arrives
  assign o_skew_clear = (cnt == '0);

  // row r is complete one cycle after row r-1
  always_comb begin
    for (int r = 0; r < N; r++) begin
      o_row_latch[r] = (cnt == CNT_WIDTH'(LATCH_BASE + r));
    end
  end

endmodule

// File: hdl/matmul_pkg.sv
package matmul_pkg;

  // element and memory sizes
  localparam int DWIDTH   = 8;
  localparam int AWIDTH   = 7;
  localparam int MEM_SIZE = 128;

  // address parked on the memories between fetches
  localparam int ADDR_IDLE = MEM_SIZE - 1;

  // array dimension and processing element pipeline depth
  localparam int N          = 4;
  localparam int MAC_CYCLES = 3;

  // control counter
  localparam int CNT_WIDTH  = 7;
  localparam int DONE_COUNT = 4 * N + 2;
  // row 0 is complete once the last operand pair has crossed the grid
  localparam int LATCH_BASE = N + 7 + MAC_CYCLES - 1;

  typedef logic signed [DWIDTH-1:0] elem_t;

  // one memory word, lane0 in the low byte
  typedef struct packed {
    elem_t lane3;
    elem_t lane2;
    elem_t lane1;
    elem_t lane0;
  } vec_t;

  // one latch strobe per result row
  typedef logic [N-1:0] row_strobe_t;

endpackage

// File: hdl/matmul_top.sv
`timescale 1ns/1ps

module matmul_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          i_start,
  output logic                          o_done,
  input  matmul_pkg::vec_t              i_a_data,
  input  matmul_pkg::vec_t              i_b_data,
  output logic [matmul_pkg::AWIDTH-1:0] o_a_addr,
  output logic [matmul_pkg::AWIDTH-1:0] o_b_addr,
  output matmul_pkg::vec_t              o_c_data
);
  import matmul_pkg::*;

  logic        skew_clear;
  row_strobe_t row_latch;
  vec_t        a_skewed;
  vec_t        b_skewed;
  vec_t        c_rows [N];

  matmul_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .i_start      (i_start),
    .o_done       (o_done),
    .o_a_addr     (o_a_addr),
    .o_b_addr     (o_b_addr),
    .o_skew_clear (skew_clear),
    .o_row_latch  (row_latch)
  );

  // A lanes feed the rows of the grid
  input_skew u_skew_a (
    .clk     (clk),
    .reset   (reset),
    .i_clear (skew_clear),
    .i_word  (i_a_data),
    .o_word  (a_skewed)
  );

  // B lanes feed the columns of the grid
  input_skew u_skew_b (
    .clk     (clk),
    .reset   (reset),
    .i_clear (skew_clear),
    .i_word  (i_b_data),
    .o_word  (b_skewed)
  );

  pe_array u_array (
    .clk   (clk),
    .reset (reset),
    .i_a   (a_skewed),
    .i_b   (b_skewed),
    .o_c   (c_rows)
  );

  result_shifter u_shifter (
    .clk      (clk),
    .reset    (reset),
    .i_latch  (row_latch),
    .i_rows   (c_rows),
    .o_c_data (o_c_data)
  );

endmodule

// File: hdl/pe_array.sv
`timescale 1ns/1ps

module pe_array (
  input  logic             clk,
  input  logic             reset,
  input  matmul_pkg::vec_t i_a,
  input  matmul_pkg::vec_t i_b,
  output matmul_pkg::vec_t o_c [matmul_pkg::N]
);
  import matmul_pkg::*;

  elem_t [N-1:0] a_lanes;
  elem_t [N-1:0] b_lanes;
  // links indexed [row][col], the extra column and row catch the edge outputs
  elem_t         a_link [N][N+1];
  elem_t         b_link [N+1][N];
  elem_t [N-1:0] acc_row [N];

  assign a_lanes = i_a;
  assign b_lanes = i_b;

  for (genvar i = 0; i < N; i++) begin : g_edge
    // lane i of A enters row i, lane i of B enters column i
    assign a_link[i][0] = a_lanes[i];
    assign b_link[0][i] = b_lanes[i];
    assign o_c[i]       = acc_row[i];
  end

  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      processing_element u_pe (
        .clk   (clk),
        .reset (reset),
        .i_a   (a_link[i][j]),
        .i_b   (b_link[i][j]),
        .o_a   (a_link[i][j+1]),
        .o_b   (b_link[i+1][j]),
        .o_acc (acc_row[i][j])
      );
    end
  end

endmodule

// File: hdl/processing_element.sv
`timescale 1ns/1ps

module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  matmul_pkg::elem_t i_a,
  input  matmul_pkg::elem_t i_b,
  output matmul_pkg::elem_t o_a,
  output matmul_pkg::elem_t o_b,
  output matmul_pkg::elem_t o_acc
);
  import matmul_pkg::*;

  elem_t                      a_mul;
  elem_t                      b_mul;
  logic signed [2*DWIDTH-1:0] product;
  logic                       prod_neg;
  logic                       prod_high;
  elem_t                      cast;
  elem_t                      cast_q;
  elem_t                      acc;

  // forwarding copy and multiplier copy are taken on the same edge
  always_ff @(posedge clk) begin
    if (reset) begin
      o_a   <= '0;
      o_b   <= '0;
      a_mul <= '0;
      b_mul <= '0;
    end else begin
      o_a   <= i_a;
      o_b   <= i_b;
      a_mul <= i_a;
      b_mul <= i_b;
    end
  end

  assign product   = a_mul * b_mul;
  assign prod_neg  = product[2*DWIDTH-1];
  assign prod_high = |product[2*DWIDTH-2:DWIDTH-1];

  // reduce the 16-bit product to 8 bits
  always_comb begin
    if (!prod_neg && prod_high) begin
      // positive overflow clamps to 127
      cast = {1'b0, {(DWIDTH-1){1'b1}}};
    end else if (prod_neg && !prod_high) begin
      // negative with bits 14:7 all clear goes to -128
      cast = {1'b1, {(DWIDTH-1){1'b0}}};
    end else begin
      cast = {prod_neg, product[DWIDTH-2:0]};
    end
  end

  // accumulator wraps in 8 bits and is only cleared by reset
  always_ff @(posedge clk) begin
    if (reset) begin
      cast_q <= '0;
      acc    <= '0;
    end else begin
      cast_q <= cast;
      acc    <= acc + cast_q;
    end
  end

  assign o_acc = acc;

endmodule

// File: hdl/result_shifter.sv
`timescale 1ns/1ps

module result_shifter (
  input  logic                    clk,
  input  logic                    reset,
  input  matmul_pkg::row_strobe_t i_latch,
  input  matmul_pkg::vec_t        i_rows [matmul_pkg::N],
  output matmul_pkg::vec_t        o_c_data
);
  import matmul_pkg::*;

  vec_t          row_q [N];
  elem_t [N-1:0] heads;

  always_ff @(posedge clk) begin
    for (int r = 0; r < N; r++) begin
      if (reset) begin
        row_q[r] <= '0;
      end else if (i_latch[r]) begin
        row_q[r] <= i_rows[r];
      end else begin
        // move every lane down by one, lane3 refills with zero
        row_q[r] <= row_q[r] >> DWIDTH;
      end
    end
  end

  // the head of row r drives lane r of the output
  always_comb begin
    for (int r = 0; r < N; r++) begin
      heads[r] = row_q[r].lane0;
    end
  end

  assign o_c_data = heads;

endmodule

// File: matmul_top.f
+incdir+include
hdl/matmul_pkg.sv
hdl/processing_element.sv
hdl/input_skew.sv
hdl/pe_array.sv
hdl/result_shifter.sv
hdl/matmul_ctrl.sv
hdl/matmul_top.sv
tb/matmul_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the matmul testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  -f matmul_top.f --top-module matmul_tb -o matmul_sim

./obj_dir/matmul_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "TEST OK" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"

// File: include/matmul_tb_checks.svh
`ifndef MATMUL_TB_CHECKS_SVH
`define MATMUL_TB_CHECKS_SVH

int pass_count = 0;
int fail_count = 0;

// common bookkeeping for every compare
task automatic report_check(input bit ok, input string name,
                            input string got, input string want);
  if (ok) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("CHECK FAILED at %0t: %s got %s expected %s", $time, name, got, want);
  end
endtask

// result word, shown lane3 first
task automatic check_vec(input string name, input matmul_pkg::vec_t got,
                         input matmul_pkg::vec_t want);
  report_check(got === want, name,
               $sformatf("%0d %0d %0d %0d", got.lane3, got.lane2, got.lane1, got.lane0),
               $sformatf("%0d %0d %0d %0d", want.lane3, want.lane2, want.lane1, want.lane0));
endtask

task automatic check_bit(input string name, input logic got, input logic want);
  report_check(got === want, name, $sformatf("%b", got), $sformatf("%b", want));
endtask

task automatic check_addr(input string name,
                          input logic [matmul_pkg::AWIDTH-1:0] got,
                          input logic [matmul_pkg::AWIDTH-1:0] want);
  report_check(got === want, name, $sformatf("%0d", got), $sformatf("%0d", want));
endtask

`endif

// File: tb/matmul_tb.sv
`timescale 1ns/1ps

module matmul_tb;
  import matmul_pkg::*;

  `include "matmul_tb_checks.svh"

  // six tests of about 40 cycles each, plus margin
  localparam int TEST_CYCLES    = 40;
  localparam int TIMEOUT_CYCLES = 6 * TEST_CYCLES + 160;
  // last cycle in which a result lane is valid
  localparam int LAST_EDGE = LATCH_BASE + 2 * N - 1;

  logic              clk     = 1'b0;
  logic              reset   = 1'b1;
  logic              i_start = 1'b0;
  vec_t              a_data  = '0;
  vec_t              b_data  = '0;
  logic              o_done;
  logic [AWIDTH-1:0] a_addr;
  logic [AWIDTH-1:0] b_addr;
  vec_t              c_data;

  vec_t  mem_a [MEM_SIZE];
  vec_t  mem_b [MEM_SIZE];
  elem_t a_mat [N][N];
  elem_t b_mat [N][N];
  elem_t got_c [N][N];
  int    edges_high  = 0;
  int    cycle_count = 0;
  int    mark_fail   = 0;
  int    mark_total  = 0;
  bit    chk_addr    = 1'b0;
  bit    chk_done    = 1'b0;
  bit    chk_data    = 1'b0;

  matmul_top i_matmul_top (
    .clk      (clk),
    .reset    (reset),
    .i_start  (i_start),
    .o_done   (o_done),
    .i_a_data (a_data),
    .i_b_data (b_data),
    .o_a_addr (a_addr),
    .o_b_addr (b_addr),
    .o_c_data (c_data)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // both memories answer one cycle after the address
  always @(posedge clk) begin
    a_data <= mem_a[a_addr];
    b_data <= mem_b[b_addr];
  end

  // edges seen with start high since it last rose
  always @(posedge clk) begin
    if (reset || !i_start) begin
      edges_high <= 0;
    end else begin
      edges_high <= edges_high + 1;
    end
  end

  // 16-bit product reduced to 8 bits
  function automatic elem_t downcast(input int p);
    if (p >= 0) begin
      if (p >= 128) begin
        return 8'sd127;
      end
      return elem_t'(p);
    end
    // only -32768..-32641 have bits 14:7 all clear
    if (p < -32640) begin
      return -8'sd128;
    end
    return elem_t'(-128 + (p & 127));
  endfunction

  function automatic elem_t ref_element(input int r, input int c);
    int sum;
    sum = 0;
    for (int k = 0; k < N; k++) begin
      sum += int'(downcast(int'(a_mat[r][k]) * int'(b_mat[k][c])));
    end
    // low byte of the sum is the wrapped 8-bit total
    return elem_t'(sum);
  endfunction

  function automatic vec_t make_vec(input elem_t l0, input elem_t l1,
                                    input elem_t l2, input elem_t l3);
    vec_t v;
    v.lane0 = l0;
    v.lane1 = l1;
    v.lane2 = l2;
    v.lane3 = l3;
    return v;
  endfunction

  function automatic elem_t lane_of(input vec_t v, input int idx);
    case (idx)
      0:       return v.lane0;
      1:       return v.lane1;
      2:       return v.lane2;
      default: return v.lane3;
    endcase
  endfunction

  // words 0..3 are shown while 1..4 edges have passed
  function automatic logic [AWIDTH-1:0] expected_addr(input int edges);
    if (edges >= 1 && edges <= N) begin
      return AWIDTH'(edges - 1);
    end
    return AWIDTH'(ADDR_IDLE);
  endfunction

  function automatic elem_t rand_small();
    return elem_t'(int'($urandom_range(22)) - 11);
  endfunction

  function automatic elem_t rand_large();
    int m;
    m = 64 + int'($urandom_range(63));
    if ($urandom_range(1) == 1) begin
      m = -m;
    end
    return elem_t'(m);
  endfunction

  // comparison process, outputs are stable at the falling edge
  always @(negedge clk) begin
    int j;
    if (i_start) begin
      if (chk_addr) begin
        check_addr("o_a_addr", a_addr, expected_addr(edges_high));
        check_addr("o_b_addr", b_addr, expected_addr(edges_high));
      end
      if (chk_done) begin
        check_bit("o_done", o_done, edges_high > DONE_COUNT);
      end
      if (chk_data) begin
        for (int r = 0; r < N; r++) begin
          j = edges_high - LATCH_BASE - 1 - r;
          if (j >= 0 && j < N) begin
            got_c[r][j] = lane_of(c_data, r);
          end
        end
      end
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    reset   <= 1'b1;
    i_start <= 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic load_memories();
    for (int w = 0; w < MEM_SIZE; w++) begin
      mem_a[w] = '0;
      mem_b[w] = '0;
    end
    // word k is column k of A and row k of B
    for (int k = 0; k < N; k++) begin
      mem_a[k] = make_vec(a_mat[0][k], a_mat[1][k], a_mat[2][k], a_mat[3][k]);
      mem_b[k] = make_vec(b_mat[k][0], b_mat[k][1], b_mat[k][2], b_mat[k][3]);
    end
  endtask

  task automatic run_operation();
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        got_c[r][c] = '0;
      end
    end
    load_memories();
    apply_reset();
    @(posedge clk);
    i_start <= 1'b1;
    while (o_done !== 1'b1) @(negedge clk);
    while (edges_high <= LAST_EDGE) @(negedge clk);
    @(posedge clk);
    i_start <= 1'b0;
    if (chk_done) begin
      // done holds until the control sees start low
      @(negedge clk);
      check_bit("o_done after stop", o_done, 1'b1);
      @(negedge clk);
      check_bit("o_done after stop", o_done, 1'b0);
    end
  endtask

  task automatic check_results();
    for (int r = 0; r < N; r++) begin
      check_vec($sformatf("o_c_data row %0d", r),
                make_vec(got_c[r][0], got_c[r][1], got_c[r][2], got_c[r][3]),
                make_vec(ref_element(r, 0), ref_element(r, 1),
                         ref_element(r, 2), ref_element(r, 3)));
    end
    @(negedge clk);
    check_vec("o_c_data after drain", c_data, '0);
  endtask

  task automatic start_test();
    mark_fail  = fail_count;
    mark_total = pass_count + fail_count;
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %0d checks, %0d failed", name,
             pass_count + fail_count - mark_total, fail_count - mark_fail);
  endtask

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: tests did not finish");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    void'($urandom(36129));
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        a_mat[r][c] = '0;
        b_mat[r][c] = '0;
      end
    end

    start_test();
    load_memories();
    apply_reset();
    @(negedge clk);
    check_bit("o_done", o_done, 1'b0);
    check_addr("o_a_addr", a_addr, AWIDTH'(ADDR_IDLE));
    check_addr("o_b_addr", b_addr, AWIDTH'(ADDR_IDLE));
    check_vec("o_c_data", c_data, '0);
    finish_test("reset state");

    start_test();
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        a_mat[r][c] = rand_small();
        b_mat[r][c] = rand_small();
      end
    end
    chk_addr = 1'b1;
    run_operation();
    chk_addr = 1'b0;
    finish_test("address sequence");

    start_test();
    chk_done = 1'b1;
    run_operation();
    chk_done = 1'b0;
    finish_test("done timing");

    start_test();
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        a_mat[r][c] = elem_t'((r == c) ? 1 : 0);
        b_mat[r][c] = rand_small();
      end
    end
    chk_data = 1'b1;
    run_operation();
    check_results();
    finish_test("identity times B");

    start_test();
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        a_mat[r][c] = rand_small();
        b_mat[r][c] = rand_small();
      end
    end
    run_operation();
    check_results();
    finish_test("random small operands");

    start_test();
    // large magnitudes push most products past the 8-bit range
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        a_mat[r][c] = rand_large();
        b_mat[r][c] = rand_large();
      end
    end
    run_operation();
    check_results();
    chk_data = 1'b0;
    finish_test("saturation");

    $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
